//--- design/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // host control word, also the readback value
    typedef struct packed {
        logic        run;
        logic        load;
        logic [19:0] rsvd;   // reads back as zero
        logic [4:0]  start_y;
        logic [4:0]  start_x;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] addr;   // byte address
        logic        wr;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- design/cell_grid.sv
`timescale 1ns/10ps
`default_nettype none
`include "path_cfg.svh"

module cell_grid (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              i_rst,
    input  wire path_pkg::idx_t    i_clr_idx,
    input  wire logic              i_clr_en,
    input  wire logic              i_ld_en,
    input  wire path_pkg::idx_t    i_idx,
    input  wire path_pkg::weight_t i_weight,
    output logic                   o_active,
    output path_pkg::dir_e         o_sel_dir
);
    import path_pkg::*;

    localparam int DIM   = `PATH_DIM;
    localparam int CELLS = DIM * DIM;

    // row and column step per neighbour, N first then clockwise
    localparam int DY [8] = '{-1, -1, 0, 1, 1, 1, 0, -1};
    localparam int DX [8] = '{0, 1, 1, 1, 0, -1, -1, -1};

    cost_t [CELLS-1:0] cost;
    dir_e              dir [CELLS];
    logic [CELLS-1:0]  mod;
    logic [CELLS-1:0]  ld_sel;
    logic [CELLS-1:0]  clr_sel;

    always_comb begin
        ld_sel             = '0;
        clr_sel            = '0;
        ld_sel[i_idx]      = i_ld_en;
        clr_sel[i_clr_idx] = i_clr_en;
    end

    for (genvar r = 0; r < DIM; r++) begin : g_row
        for (genvar c = 0; c < DIM; c++) begin : g_col
            localparam int ID = r * DIM + c;
            cost_t [7:0] nbr;

            for (genvar k = 0; k < 8; k++) begin : g_nbr
                localparam int NR = r + DY[k];
                localparam int NC = c + DX[k];
                if (NR < 0 || NR >= DIM || NC < 0 || NC >= DIM) begin : g_edge
                    assign nbr[k] = COST_INF;  // off the grid
                end else begin : g_link
                    assign nbr[k] = cost[NR * DIM + NC];
                end
            end

            path_cell path_cell_inst (
                .clk        (clk),
                .arst_n     (arst_n),
                .i_rst      (i_rst),
                .i_clr      (clr_sel[ID]),
                .i_ld       (ld_sel[ID]),
                .i_weight   (i_weight),
                .i_nbr_cost (nbr),
                .o_cost     (cost[ID]),
                .o_dir      (dir[ID]),
                .o_mod      (mod[ID])
            );
        end
    end

    assign o_active  = |mod;
    assign o_sel_dir = dir[i_idx];

endmodule

`default_nettype wire

//--- design/map_sequencer.sv
`timescale 1ns/10ps
`default_nettype none
`include "path_cfg.svh"

module map_sequencer (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              i_ctrl_wr,
    input  wire bus_pkg::ctrl_t    i_ctrl,
    output bus_pkg::ctrl_t         o_ctrl,
    output logic                   o_mem_req,
    output bus_pkg::mem_req_t      o_mem,
    input  wire logic              i_mem_rdy,
    input  wire bus_pkg::mem_rsp_t i_mem,
    output logic                   o_done,
    output logic                   o_cell_rst,
    output logic                   o_clr_en,
    output path_pkg::idx_t         o_clr_idx,
    output logic                   o_ld_en,
    output path_pkg::idx_t         o_idx,
    output path_pkg::weight_t      o_weight,
    input  wire logic              i_active,
    input  wire path_pkg::dir_e    i_sel_dir
);
    import path_pkg::*;
    import bus_pkg::*;

    localparam int CELLS = `PATH_DIM * `PATH_DIM;
    localparam int WORDS = (CELLS + 7) / 8;       // 8 nibbles per word
    localparam int OFF_W = $clog2(WORDS + 1);
    localparam int HIST  = `PATH_HISTORY;

    seq_state_e       state_q;
    seq_state_e       state_d;
    ctrl_t            ctrl_q;
    idx_t             curr_q;
    logic [OFF_W-1:0] off_q;         // word offset into either window
    logic [HIST-1:0]  hist_q;
    logic [31:0]      data_q;
    logic [31:0]      nxt_q;         // read-ahead word caught during unpack
    logic             nxt_full_q;
    logic [31:0]      rd_word;
    logic [31:0]      pack_word;
    logic             nib_last;
    logic             cell_last;
    logic             take;
    logic             rd_issue;
    logic             wr_issue;

    assign o_ctrl    = ctrl_q;
    assign nib_last  = curr_q[2:0] == 3'd7;
    assign cell_last = curr_q == idx_t'(CELLS - 1);
    assign rd_word   = nxt_full_q ? nxt_q : i_mem.rdata;

    assign o_idx     = curr_q;
    assign o_weight  = data_q[curr_q[2:0] * 4 +: 4];
    assign o_clr_en  = state_q == RUNNING;
    assign o_clr_idx = idx_t'(ctrl_q.start_y * `PATH_DIM + ctrl_q.start_x);

    always_comb begin
        pack_word                        = data_q;
        pack_word[curr_q[2:0] * 4 +: 4] = i_sel_dir;
    end

    always_comb begin
        state_d    = state_q;
        take       = 1'b0;
        wr_issue   = 1'b0;
        o_cell_rst = 1'b0;
        o_ld_en    = 1'b0;
        case (state_q)
            IDLE: begin
                if (ctrl_q.load) begin
                    state_d = RD_FIRST;
                end else if (ctrl_q.run) begin
                    o_cell_rst = 1'b1;
                    state_d    = RUNNING;
                end
            end
            RD_FIRST: state_d = WAIT_FIRST;
            WAIT_FIRST, WAIT_RD: begin
                if (i_mem_rdy) begin
                    take    = 1'b1;
                    state_d = UNPACK;
                end
            end
            UNPACK: begin
                o_ld_en = 1'b1;
                if (cell_last) begin
                    state_d = IDLE;
                end else if (nib_last) begin
                    if (nxt_full_q || i_mem_rdy) take = 1'b1;  // next word already here
                    else state_d = WAIT_RD;
                end
            end
            RUNNING: if (hist_q == '0) state_d = PACK;
            PACK: begin
                wr_issue = nib_last || cell_last;
                if (cell_last) state_d = WAIT_LAST_WR;
                else if (nib_last) state_d = WAIT_WR;
            end
            WAIT_WR: if (i_mem_rdy) state_d = PACK;
            WAIT_LAST_WR: if (i_mem_rdy) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // never read past the last map word
    assign rd_issue  = (state_q == RD_FIRST) || (take && off_q != OFF_W'(WORDS));
    assign o_mem_req = rd_issue || wr_issue;

    always_comb begin
        o_mem.wr    = wr_issue;
        o_mem.wdata = pack_word;
        if (wr_issue) o_mem.addr = `PATH_DIR_BASE + (32'(off_q) << 2);
        else o_mem.addr = `PATH_MAP_BASE + (32'(off_q) << 2);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= IDLE;
            ctrl_q     <= '0;
            curr_q     <= '0;
            off_q      <= '0;
            hist_q     <= '0;
            nxt_full_q <= 1'b0;
            o_done     <= 1'b0;
        end else begin
            state_q <= state_d;
            o_done  <= (state_q == WAIT_LAST_WR) && i_mem_rdy;
            hist_q  <= o_cell_rst ? '1 : {hist_q[HIST-2:0], i_active};

            // host writes only land when nothing is pending
            if (i_ctrl_wr && state_q == IDLE && !ctrl_q.run && !ctrl_q.load) begin
                ctrl_q      <= i_ctrl;
                ctrl_q.rsvd <= '0;
            end
            if (state_q == UNPACK && cell_last) ctrl_q.load <= 1'b0;
            if (state_q == WAIT_LAST_WR && i_mem_rdy) ctrl_q.run <= 1'b0;

            if (state_q == IDLE || state_q == RUNNING) begin
                curr_q <= '0;
                off_q  <= '0;
            end
            if (o_ld_en || state_q == PACK) curr_q <= curr_q + 1'b1;
            if (rd_issue || (state_q == WAIT_WR && i_mem_rdy)) off_q <= off_q + 1'b1;

            if (take) nxt_full_q <= 1'b0;
            else if (i_mem_rdy && state_q == UNPACK) nxt_full_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) data_q <= rd_word;
        else if (state_q == PACK) data_q <= pack_word;
        if (i_mem_rdy && state_q == UNPACK && !take) nxt_q <= i_mem.rdata;
    end

endmodule

`default_nettype wire

//--- design/path_cell.sv
`timescale 1ns/10ps
`default_nettype none

module path_cell (
    input  wire logic                    clk,
    input  wire logic                    arst_n,
    input  wire logic                    i_rst,
    input  wire logic                    i_clr,
    input  wire logic                    i_ld,
    input  wire path_pkg::weight_t       i_weight,
    input  wire path_pkg::cost_t [7:0]   i_nbr_cost,
    output path_pkg::cost_t              o_cost,
    output path_pkg::dir_e               o_dir,
    output logic                         o_mod
);
    import path_pkg::*;

    weight_t                weight_q;
    cost_t                  best_cost;
    dir_e                   best_dir;
    logic [$bits(cost_t):0] sum;
    cost_t                  cand;
    logic                   relax;

    // cheapest neighbour, first one wins a tie
    always_comb begin
        best_cost = COST_INF;
        best_dir  = DIR_NONE;
        for (int k = 0; k < 8; k++) begin
            if (i_nbr_cost[k] < best_cost) begin
                best_cost = i_nbr_cost[k];
                best_dir  = dir_e'(k + 1);
            end
        end
        sum  = {1'b0, best_cost} + ($bits(cost_t) + 1)'(weight_q);
        cand = sum[$bits(cost_t)] ? COST_INF : sum[$bits(cost_t)-1:0];  // saturate
    end

    assign relax = !i_rst && !i_clr && (weight_q != WEIGHT_WALL) && (cand < o_cost);
    assign o_mod = relax;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            o_cost <= COST_INF;
            o_dir  <= DIR_NONE;
        end else if (i_rst) begin
            o_cost <= COST_INF;
            o_dir  <= DIR_NONE;
        end else if (i_clr) begin
            o_cost <= '0;        // start cell
            o_dir  <= DIR_NONE;
        end else if (relax) begin
            o_cost <= cand;
            o_dir  <= best_dir;
        end
    end

    always_ff @(posedge clk) begin
        if (i_ld) weight_q <= i_weight;
    end

endmodule

`default_nettype wire

//--- design/path_cfg.svh
`ifndef PATH_CFG_SVH
`define PATH_CFG_SVH

// grid geometry and cost arithmetic
`define PATH_DIM      4
`define PATH_COST_W   9
`define PATH_WEIGHT_W 4

`define PATH_HISTORY  16            // quiet cycles before a run is called converged

// byte addresses of the two memory windows
`define PATH_MAP_BASE 32'h4000_0000
`define PATH_DIR_BASE 32'h4000_2000

`endif

//--- design/path_fabric.sv
`timescale 1ns/10ps
`default_nettype none

module path_fabric (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              i_ctrl_wr,
    input  wire bus_pkg::ctrl_t    i_ctrl,
    output bus_pkg::ctrl_t         o_ctrl,
    output logic                   o_mem_req,
    output bus_pkg::mem_req_t      o_mem,
    input  wire logic              i_mem_rdy,
    input  wire bus_pkg::mem_rsp_t i_mem,
    output logic                   o_done
);
    import path_pkg::*;

    logic    cell_rst;
    logic    clr_en;
    idx_t    clr_idx;
    logic    ld_en;
    idx_t    idx;      // load target or packed cell
    weight_t weight;
    logic    active;
    dir_e    sel_dir;

    map_sequencer map_sequencer_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .i_ctrl_wr  (i_ctrl_wr),
        .i_ctrl     (i_ctrl),
        .o_ctrl     (o_ctrl),
        .o_mem_req  (o_mem_req),
        .o_mem      (o_mem),
        .i_mem_rdy  (i_mem_rdy),
        .i_mem      (i_mem),
        .o_done     (o_done),
        .o_cell_rst (cell_rst),
        .o_clr_en   (clr_en),
        .o_clr_idx  (clr_idx),
        .o_ld_en    (ld_en),
        .o_idx      (idx),
        .o_weight   (weight),
        .i_active   (active),
        .i_sel_dir  (sel_dir)
    );

    cell_grid cell_grid_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .i_rst     (cell_rst),
        .i_clr_idx (clr_idx),
        .i_clr_en  (clr_en),
        .i_ld_en   (ld_en),
        .i_idx     (idx),
        .i_weight  (weight),
        .o_active  (active),
        .o_sel_dir (sel_dir)
    );

endmodule

`default_nettype wire

//--- design/path_pkg.sv
`default_nettype none
`include "path_cfg.svh"

package path_pkg;

    typedef logic [`PATH_COST_W-1:0]                  cost_t;
    typedef logic [`PATH_WEIGHT_W-1:0]                weight_t;
    typedef logic [$clog2(`PATH_DIM * `PATH_DIM)-1:0] idx_t;

    localparam cost_t   COST_INF    = '1;  // unreached cell or off-grid border
    localparam weight_t WEIGHT_WALL = '1;

    // neighbour order is the order the cell scans in
    typedef enum logic [3:0] {
        DIR_NONE = 4'd0,
        DIR_N, DIR_NE, DIR_E, DIR_SE,
        DIR_S, DIR_SW, DIR_W, DIR_NW
    } dir_e;

    typedef enum logic [3:0] {
        IDLE,
        RD_FIRST,
        WAIT_FIRST,
        UNPACK,
        WAIT_RD,
        RUNNING,
        PACK,
        WAIT_WR,
        WAIT_LAST_WR
    } seq_state_e;

endpackage

`default_nettype wire

//--- dv/tb_path_fabric.sv
`timescale 1ns/10ps
`default_nettype none
`include "path_cfg.svh"

module tb_path_fabric;
    import path_pkg::*;
    import bus_pkg::*;

    localparam int DIM   = `PATH_DIM;
    localparam int CELLS = DIM * DIM;
    localparam int WORDS = (CELLS + 7) / 8;
    localparam int WALL  = 15;
    localparam int INF   = 32'h0000_ffff;  // model cost of a cell never reached
    localparam int LIMIT = 500;            // cycles allowed for any single wait

    // N first, then clockwise
    localparam int STEP_Y [8] = '{-1, -1, 0, 1, 1, 1, 0, -1};
    localparam int STEP_X [8] = '{0, 1, 1, 1, 0, -1, -1, -1};

    logic     clk = 1'b0;
    logic     arst_n;
    logic     i_ctrl_wr;
    ctrl_t    i_ctrl;
    ctrl_t    o_ctrl;
    logic     o_mem_req;
    mem_req_t o_mem;
    logic     i_mem_rdy;
    mem_rsp_t i_mem;
    logic     o_done;

    logic [31:0] rnd_state = 32'h500c_472e;
    logic [31:0] map_mem [WORDS];
    logic [31:0] dir_mem [WORDS];
    logic [31:0] rd_log [$];
    logic [31:0] wr_log [$];
    int          weights [CELLS];
    int          model_cost [CELLS];

    path_fabric path_fabric_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .i_ctrl_wr (i_ctrl_wr),
        .i_ctrl    (i_ctrl),
        .o_ctrl    (o_ctrl),
        .o_mem_req (o_mem_req),
        .o_mem     (o_mem),
        .i_mem_rdy (i_mem_rdy),
        .i_mem     (i_mem),
        .o_done    (o_done)
    );

    always #50 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            rnd_state = lfsr_next(rnd_state);
            v = {v[30:0], rnd_state[0]};
        end
        return v;
    endfunction

    task automatic report_fail(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            report_fail($sformatf("ERROR %s: got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    function automatic ctrl_t make_ctrl(input logic run, input logic load,
                                        input int y, input int x);
        ctrl_t c;
        c         = '0;
        c.run     = run;
        c.load    = load;
        c.start_y = 5'(y);
        c.start_x = 5'(x);
        return c;
    endfunction

    // memory with a random 1 to 4 cycle answer
    initial begin : memory_model
        logic        busy;
        int          delay;
        logic [31:0] rdata;
        logic [31:0] offs;
        logic        req;
        mem_req_t    req_q;
        busy      = 1'b0;
        delay     = 0;
        rdata     = '0;
        req       = 1'b0;
        req_q     = '0;
        i_mem_rdy = 1'b0;
        i_mem     = '0;
        forever begin
            @(negedge clk);
            req   = o_mem_req;   // sampled mid cycle
            req_q = o_mem;
            @(posedge clk);
            i_mem_rdy <= 1'b0;
            if (busy) begin
                if (delay == 0) begin
                    i_mem_rdy   <= 1'b1;
                    i_mem.rdata <= rdata;
                    busy = 1'b0;
                end else begin
                    delay--;
                end
            end
            if (req) begin
                if (busy) report_fail("memory request issued while another one is outstanding");
                if (req_q.wr) begin
                    wr_log.push_back(req_q.addr);
                    offs = (req_q.addr - `PATH_DIR_BASE) >> 2;
                    if (offs >= WORDS || req_q.addr[1:0] != 2'b00)
                        report_fail("memory write outside the direction window");
                    else
                        dir_mem[offs] = req_q.wdata;
                end else begin
                    rd_log.push_back(req_q.addr);
                    offs = (req_q.addr - `PATH_MAP_BASE) >> 2;
                    if (offs >= WORDS || req_q.addr[1:0] != 2'b00)
                        report_fail("memory read outside the weight map window");
                    else
                        rdata = map_mem[offs];
                end
                busy  = 1'b1;
                delay = int'(rand_bits(2));
            end
        end
    end

    task automatic write_ctrl(input ctrl_t c);
        @(posedge clk);
        i_ctrl_wr <= 1'b1;
        i_ctrl    <= c;
        @(posedge clk);
        i_ctrl_wr <= 1'b0;
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value("o_mem_req", 32'(o_mem_req), 0);
            check_value("o_done", 32'(o_done), 0);
        end
    endtask

    // mode 0 has no walls, mode 1 scattered walls, mode 2 a fenced pocket
    task automatic make_map(input int mode, input int start);
        int w;
        for (int i = 0; i < CELLS; i++) begin
            w = int'(rand_bits(4));
            if (mode == 0 && w == WALL) w = 14;
            if (mode == 1 && rand_bits(2) == 0) w = WALL;
            weights[i] = w;
        end
        if (mode == 2) begin
            for (int k = 0; k < 3; k++) begin
                weights[2 * DIM + k] = WALL;  // row 2
                weights[k * DIM + 2] = WALL;  // column 2
            end
        end
        if (weights[start] == WALL) weights[start] = 1;
        for (int i = 0; i < WORDS; i++) map_mem[i] = '0;
        for (int i = 0; i < CELLS; i++) map_mem[i / 8][(i % 8) * 4 +: 4] = 4'(weights[i]);
    endtask

    // relax until nothing changes
    task automatic solve_model(input int start);
        logic changed;
        int   ny;
        int   nx;
        int   best;
        for (int i = 0; i < CELLS; i++) model_cost[i] = INF;
        model_cost[start] = 0;
        changed = 1'b1;
        while (changed) begin
            changed = 1'b0;
            for (int i = 0; i < CELLS; i++) begin
                if (i != start && weights[i] != WALL) begin
                    best = INF;
                    for (int k = 0; k < 8; k++) begin
                        ny = i / DIM + STEP_Y[k];
                        nx = i % DIM + STEP_X[k];
                        if (ny >= 0 && ny < DIM && nx >= 0 && nx < DIM) begin
                            if (model_cost[ny * DIM + nx] < best) best = model_cost[ny * DIM + nx];
                        end
                    end
                    if (best < INF && best + weights[i] < model_cost[i]) begin
                        model_cost[i] = best + weights[i];
                        changed = 1'b1;
                    end
                end
            end
        end
    endtask

    task automatic do_load();
        ctrl_t c;
        int    n;
        c = make_ctrl(1'b0, 1'b1, 0, 0);
        rd_log.delete();
        wr_log.delete();
        write_ctrl(c);
        @(negedge clk);
        check_value("o_ctrl", o_ctrl, c);
        write_ctrl(make_ctrl(1'b1, 1'b0, 2, 1));  // must be dropped while busy
        @(negedge clk);
        check_value("o_ctrl", o_ctrl, c);
        n = 0;
        while (o_ctrl.load) begin
            @(negedge clk);
            n++;
            if (n > LIMIT) report_fail("timeout waiting for the load job to finish");
        end
        check_value("o_ctrl", o_ctrl, 0);
        check_idle(8);
        check_value("map read count", 32'(rd_log.size()), WORDS);
        check_value("write count during load", 32'(wr_log.size()), 0);
        foreach (rd_log[i]) check_value("map read addr", rd_log[i], `PATH_MAP_BASE + 32'(i) * 4);
    endtask

    task automatic do_run(input int sy, input int sx);
        ctrl_t c;
        int    n;
        int    d;
        int    ny;
        int    nx;
        int    start;
        start = sy * DIM + sx;
        c = make_ctrl(1'b1, 1'b0, sy, sx);
        rd_log.delete();
        wr_log.delete();
        for (int w = 0; w < WORDS; w++) dir_mem[w] = ~(`PATH_DIR_BASE + 32'(w) * 4);
        write_ctrl(c);
        @(negedge clk);
        check_value("o_ctrl", o_ctrl, c);
        write_ctrl(make_ctrl(1'b0, 1'b1, DIM - 1 - sy, DIM - 1 - sx));
        @(negedge clk);
        check_value("o_ctrl", o_ctrl, c);
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > LIMIT) report_fail("timeout waiting for o_done at the end of a run");
        end while (!o_done);
        check_value("o_ctrl.run", 32'(o_ctrl.run), 0);
        check_idle(2 * `PATH_HISTORY);  // a second done pulse would show here
        check_value("dir write count", 32'(wr_log.size()), WORDS);
        check_value("read count during run", 32'(rd_log.size()), 0);
        foreach (wr_log[i]) check_value("dir write addr", wr_log[i], `PATH_DIR_BASE + 32'(i) * 4);
        for (int i = 0; i < CELLS; i++) begin
            d = int'(dir_mem[i / 8][(i % 8) * 4 +: 4]);
            if (i == start || weights[i] == WALL || model_cost[i] == INF) begin
                check_value($sformatf("dir of cell %0d", i), d, 32'(DIR_NONE));
            end else begin
                check_value($sformatf("dir of cell %0d is a direction", i), 32'(d >= 1 && d <= 8), 1);
                ny = i / DIM + STEP_Y[d - 1];
                nx = i % DIM + STEP_X[d - 1];
                check_value($sformatf("dir of cell %0d on grid", i),
                            32'(ny >= 0 && ny < DIM && nx >= 0 && nx < DIM), 1);
                check_value($sformatf("cost via dir of cell %0d", i),
                            model_cost[ny * DIM + nx] + weights[i], model_cost[i]);
            end
        end
    endtask

    initial begin : test_sequence
        int sy;
        int sx;
        int mode;
        arst_n    = 1'b0;
        i_ctrl_wr = 1'b0;
        i_ctrl    = '0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("o_ctrl", o_ctrl, 0);
        check_idle(10);
        for (int job = 0; job < 6; job++) begin
            mode = job % 3;
            if (mode == 2) begin
                sy = DIM - 1;  // outside the pocket
                sx = int'(rand_bits(5)) % DIM;
            end else begin
                sy = int'(rand_bits(5)) % DIM;
                sx = int'(rand_bits(5)) % DIM;
            end
            make_map(mode, sy * DIM + sx);
            do_load();
            solve_model(sy * DIM + sx);
            do_run(sy, sx);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+design
design/path_pkg.sv
design/bus_pkg.sv
design/path_cell.sv
design/cell_grid.sv
design/map_sequencer.sv
design/path_fabric.sv
dv/tb_path_fabric.sv

//--- run.sh
#!/bin/sh
# build the path_fabric testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing -Wno-fatal -f files.f \
        --top-module tb_path_fabric --Mdir "$BUILD_DIR" -o tb_sim; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "PASS: all tests" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1
